//--- logic/board_pkg.sv
/* shared constants and types for the board register block
   timer values assume one tick per 256 sysclk cycles, at about 49 MHz
   status and command layouts assume NUM_AXES == 4 */

package board_pkg;

    // ------------------------------------------------------------------------
    // address map
    // ------------------------------------------------------------------------
    localparam logic [3:0] ADDR_MAIN   = 4'h0;   // page in addr[15:12]
    localparam logic [3:0] REG_STATUS  = 4'h0;
    localparam logic [3:0] REG_TIMEOUT = 4'h3;
    localparam logic [3:0] REG_VERSION = 4'h4;
    localparam logic [3:0] REG_TEMPSNS = 4'h5;
    localparam logic [3:0] REG_DIGIN   = 4'ha;
    localparam logic [3:0] REG_DEBUG   = 4'hf;

    localparam logic [31:0] FW_VERSION = 32'h0000_0007;

    // ------------------------------------------------------------------------
    // timing
    // ------------------------------------------------------------------------
    localparam logic [15:0] WDOG_PERIOD_RST = 16'h1680;  // about 30 ms
    localparam int          TICK_BITS       = 8;         // tick every 256 clocks
    localparam logic [15:0] MV_SETTLE_TICKS = 16'd7680;  // about 40 ms
    localparam int          NUM_AXES        = 4;

    typedef enum logic [1:0] {
        PWR_OFF  = 2'd0,
        PWR_WAIT = 2'd1,   // power on, motor voltage still settling
        PWR_ON   = 2'd2,
        PWR_TRIP = 2'd3    // watchdog trip
    } pwr_state_t;

    // status write, each value bit only acts when its mask bit is set
    typedef struct packed {
        logic [11:0]         unused;
        logic                pwr_mask;      // bit 19
        logic                pwr_value;
        logic                relay_mask;    // bit 17
        logic                relay_value;
        logic [3:0]          mask_hi;       // axes 5..8 of larger boards
        logic [NUM_AXES-1:0] amp_mask;      // bits 11:8
        logic [3:0]          value_hi;
        logic [NUM_AXES-1:0] amp_value;     // bits 3:0, 1 = enable
    } status_cmd_t;

    // same host word, seen as plain data or as power commands
    typedef union packed {
        logic [31:0] raw;
        status_cmd_t cmd;
    } wdata_u;

    typedef struct packed {
        logic [3:0]          num_chan;
        logic [3:0]          board_id;
        logic                wdog_timeout;
        logic [2:0]          reserved;
        logic                mv_good;
        logic                pwr_enable;
        logic                relay_open;
        logic                relay_on;
        logic                mv_fault;
        logic [2:0]          reserved2;
        logic [NUM_AXES-1:0] fault;
        logic [NUM_AXES-1:0] safety_amp_disable;
        logic [NUM_AXES-1:0] amp_enabled;
    } status_word_t;

    // board pins, per-axis fields with axis 1 in bit 0
    typedef struct packed {
        logic [NUM_AXES-1:0] enc_a;
        logic [NUM_AXES-1:0] enc_b;
        logic [NUM_AXES-1:0] enc_i;
        logic [NUM_AXES-1:0] neg_limit;
        logic [NUM_AXES-1:0] pos_limit;
        logic [NUM_AXES-1:0] home;
        logic [NUM_AXES-1:0] fault;
        logic                relay;       // safety relay sense
        logic                mv_faultn;   // motor supply fault, active low
        logic                mv_good;
        logic                v_fault;     // encoder supply fault
        logic [3:0]          board_id;    // rotary switch
        logic [15:0]         temp_sense;
        logic [NUM_AXES-1:0] dout_low;
        logic [NUM_AXES-1:0] safety_amp_disable;
    } board_in_t;

endpackage

//--- logic/board_reg_file.sv
/* main page of the register bus, plain write strobe and no read strobe
   reads return one cycle after reg_raddr, held during a main-page write */

module board_reg_file import board_pkg::*; (
    input  logic         sysclk,
    input  logic         rst,
    input  logic [15:0]  reg_raddr,
    input  logic [15:0]  reg_waddr,
    input  logic [31:0]  reg_wdata,
    input  logic         reg_wen,
    input  board_in_t    pins,
    input  status_word_t status,        // assembled by the power FSM
    output logic [31:0]  reg_rdata,
    output logic         status_wr,     // one-cycle pulse
    output wdata_u       wdata,
    output logic [15:0]  wdog_period
);

    logic        write_main;
    logic        read_main;
    logic [31:0] reg_debug;
    logic [31:0] digin;

    // ------------------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------------------
    // only offsets 0x00..0x0f of the page belong here
    assign write_main = reg_wen && (reg_waddr[15:12] == ADDR_MAIN)
                        && (reg_waddr[7:4] == 4'd0);
    assign read_main  = (reg_raddr[15:12] == ADDR_MAIN) && (reg_raddr[7:4] == 4'd0);
    assign status_wr  = write_main && (reg_waddr[3:0] == REG_STATUS);
    assign wdata.raw  = reg_wdata;      // FSM decodes it as cmd

    // digital inputs, bit 30 was a spare I/O and stays 0
    assign digin = {pins.v_fault, 1'b0, 2'd0,
                    pins.enc_a, pins.enc_b, pins.enc_i,
                    pins.dout_low,
                    pins.neg_limit, pins.pos_limit, pins.home};

    // ------------------------------------------------------------------------
    // writable registers
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            wdog_period <= WDOG_PERIOD_RST;
            reg_debug   <= 32'd0;
        end else if (write_main) begin
            case (reg_waddr[3:0])
                REG_TIMEOUT: wdog_period <= wdata.raw[15:0];  // 0 stops the watchdog
                REG_DEBUG:   reg_debug   <= wdata.raw;
                default: ;                  // status handled in the FSM
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // read mux, registered
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            reg_rdata <= 32'd0;
        end else if (!write_main) begin
            if (!read_main) begin
                reg_rdata <= 32'd0;         // off page
            end else begin
                case (reg_raddr[3:0])
                    REG_STATUS:  reg_rdata <= status;
                    REG_TIMEOUT: reg_rdata <= {16'd0, wdog_period};
                    REG_VERSION: reg_rdata <= FW_VERSION;
                    REG_TEMPSNS: reg_rdata <= {16'd0, pins.temp_sense};
                    REG_DIGIN:   reg_rdata <= digin;
                    REG_DEBUG:   reg_rdata <= reg_debug;
                    default:     reg_rdata <= 32'd0;
                endcase
            end
        end
    end

endmodule

//--- logic/board_timers.sv
/* watchdog and motor-voltage settle timers, both stepped by one prescaler tick
   the watchdog runs only while wdog_period is nonzero */

module board_timers import board_pkg::*; (
    input  logic        sysclk,
    input  logic        rst,
    input  logic        reg_wen,        // any host write, any page
    input  logic        wdog_clear,     // power-up command
    input  logic [15:0] wdog_period,
    input  logic        mv_good,
    output logic        wdog_timeout,   // sticky until wdog_clear
    output logic        mv_settled
);

    logic [TICK_BITS-1:0] presc;
    logic                 tick;
    logic [15:0]          wdog_count;
    logic [15:0]          mv_count;

    // ------------------------------------------------------------------------
    // prescaler
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst)
            presc <= '0;
        else
            presc <= presc + TICK_BITS'(1);  // free running
    end

    assign tick = &presc;               // one cycle in 2**TICK_BITS

    // ------------------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            wdog_count   <= 16'd0;
            wdog_timeout <= 1'b0;
        end else if (wdog_clear) begin
            wdog_count   <= 16'd0;
            wdog_timeout <= 1'b0;
        end else if (reg_wen) begin
            wdog_count   <= 16'd0;      // host is alive
        end else if (tick && (wdog_period != 16'd0)) begin
            if (wdog_count < wdog_period)
                wdog_count <= wdog_count + 16'd1;
            else
                wdog_timeout <= 1'b1;   // tick after reaching the period
        end
    end

    // ------------------------------------------------------------------------
    // motor voltage settle
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            mv_count   <= 16'd0;
            mv_settled <= 1'b0;
        end else if (!mv_good) begin
            mv_count   <= 16'd0;        // restart on any dropout
            mv_settled <= 1'b0;
        end else if (tick) begin
            if (mv_count < MV_SETTLE_TICKS)
                mv_count <= mv_count + 16'd1;
            else
                mv_settled <= 1'b1;
        end
    end

endmodule

//--- logic/power_ctrl_fsm.sv
/* board power FSM with relay control and sticky per-axis amp disables
   an axis enable only takes effect if power was already on before the write */

module power_ctrl_fsm import board_pkg::*; (
    input  logic                sysclk,
    input  logic                rst,
    input  logic                status_wr,
    input  wdata_u              wdata,
    input  logic                wdog_timeout,
    input  logic                mv_settled,
    input  logic [NUM_AXES-1:0] safety_amp_disable,
    input  logic                mv_good,
    input  logic                mv_faultn,
    input  logic                relay,
    input  logic [NUM_AXES-1:0] fault,
    input  logic [3:0]          board_id,
    output logic                pwr_enable,
    output logic                relay_on,
    output logic [NUM_AXES-1:0] amp_disable,   // to the amplifiers, 1 = off
    output logic                wdog_clear,
    output status_word_t        status
);

    pwr_state_t          state;
    pwr_state_t          state_nxt;
    logic [NUM_AXES-1:0] axis_dis;      // sticky disables
    logic [NUM_AXES-1:0] axis_dis_nxt;
    logic [NUM_AXES-1:0] amp_en_cmd;
    logic                pwr_on_cmd;
    logic                pwr_off_cmd;

    // command decode, mask and value both set
    assign pwr_on_cmd  = status_wr & wdata.cmd.pwr_mask & wdata.cmd.pwr_value;
    assign pwr_off_cmd = status_wr & wdata.cmd.pwr_mask & ~wdata.cmd.pwr_value;
    assign amp_en_cmd  = {NUM_AXES{status_wr}} & wdata.cmd.amp_mask & wdata.cmd.amp_value;
    assign wdog_clear  = pwr_on_cmd | (|amp_en_cmd);

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            PWR_OFF:
                if (pwr_on_cmd)
                    state_nxt = PWR_WAIT;
            PWR_WAIT:
                if (pwr_off_cmd)
                    state_nxt = PWR_OFF;
                else if (wdog_timeout && !wdog_clear)
                    state_nxt = PWR_TRIP;
                else if (mv_settled)
                    state_nxt = PWR_ON;
            PWR_ON:
                if (pwr_off_cmd)
                    state_nxt = PWR_OFF;
                else if (wdog_timeout && !wdog_clear)
                    state_nxt = PWR_TRIP;
                else if (!mv_settled)
                    state_nxt = PWR_WAIT;   // voltage dropped
            PWR_TRIP:
                if (pwr_on_cmd)
                    state_nxt = PWR_WAIT;   // only way out
            default:
                state_nxt = PWR_OFF;
        endcase
    end

    // ------------------------------------------------------------------------
    // sticky axis disables
    // ------------------------------------------------------------------------
    always_comb begin
        axis_dis_nxt = axis_dis;
        if (status_wr) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                if (wdata.cmd.amp_mask[i])
                    axis_dis_nxt[i] = ~wdata.cmd.amp_value[i];
            end
            if (!pwr_enable || pwr_off_cmd)
                axis_dis_nxt = '1;          // no power, no axes
        end
        if (state_nxt == PWR_TRIP)
            axis_dis_nxt = '1;
        axis_dis_nxt = axis_dis_nxt | safety_amp_disable;
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            state      <= PWR_OFF;
            pwr_enable <= 1'b0;
            relay_on   <= 1'b0;
            axis_dis   <= '1;
        end else begin
            state    <= state_nxt;
            axis_dis <= axis_dis_nxt;
            if (status_wr && wdata.cmd.pwr_mask)
                pwr_enable <= wdata.cmd.pwr_value;
            if (status_wr && wdata.cmd.relay_mask)
                relay_on <= wdata.cmd.relay_value;
        end
    end

    // all axes held off until power is on and settled
    assign amp_disable = axis_dis | {NUM_AXES{(state != PWR_ON) || !mv_settled}};

    always_comb begin
        status                    = '0;
        status.num_chan           = 4'(NUM_AXES);
        status.board_id           = board_id;
        status.wdog_timeout       = wdog_timeout;
        status.mv_good            = mv_good;
        status.pwr_enable         = pwr_enable;
        status.relay_open         = ~relay;
        status.relay_on           = relay_on;
        status.mv_fault           = ~mv_faultn;
        status.fault              = fault;       // 1 = amp ok
        status.safety_amp_disable = safety_amp_disable;
        status.amp_enabled        = ~axis_dis;
    end

endmodule

//--- logic/board_top.sv
/* board register block, main page only, single sysclk domain */

module board_top import board_pkg::*; (
    input  logic                sysclk,
    input  logic                rst,
    input  logic [15:0]         reg_raddr,
    input  logic [15:0]         reg_waddr,
    input  logic [31:0]         reg_wdata,
    input  logic                reg_wen,
    input  board_in_t           pins,
    output logic [31:0]         reg_rdata,
    output logic                pwr_enable,
    output logic                relay_on,
    output logic [NUM_AXES-1:0] amp_disable
);

    logic         status_wr;
    wdata_u       wdata;
    logic [15:0]  wdog_period;
    logic         wdog_clear;
    logic         wdog_timeout;
    logic         mv_settled;
    status_word_t status;

    board_reg_file regs0 (
        .sysclk      (sysclk),
        .rst         (rst),
        .reg_raddr   (reg_raddr),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_wen     (reg_wen),
        .pins        (pins),
        .status      (status),
        .reg_rdata   (reg_rdata),
        .status_wr   (status_wr),
        .wdata       (wdata),
        .wdog_period (wdog_period)
    );

    board_timers timers0 (
        .sysclk       (sysclk),
        .rst          (rst),
        .reg_wen      (reg_wen),     // any page resets the watchdog
        .wdog_clear   (wdog_clear),
        .wdog_period  (wdog_period),
        .mv_good      (pins.mv_good),
        .wdog_timeout (wdog_timeout),
        .mv_settled   (mv_settled)
    );

    power_ctrl_fsm pwr0 (
        .sysclk             (sysclk),
        .rst                (rst),
        .status_wr          (status_wr),
        .wdata              (wdata),
        .wdog_timeout       (wdog_timeout),
        .mv_settled         (mv_settled),
        .safety_amp_disable (pins.safety_amp_disable),
        .mv_good            (pins.mv_good),
        .mv_faultn          (pins.mv_faultn),
        .relay              (pins.relay),
        .fault              (pins.fault),
        .board_id           (pins.board_id),
        .pwr_enable         (pwr_enable),
        .relay_on           (relay_on),
        .amp_disable        (amp_disable),
        .wdog_clear         (wdog_clear),
        .status             (status)
    );

endmodule

//--- testbench/tb_board_model.svh
/* reference model of the main register page and the power states
   included inside tb_board, works on its m_ variables and pins */

`ifndef TB_BOARD_MODEL_SVH
`define TB_BOARD_MODEL_SVH

// ----------------------------------------------------------------------------
// model state
// ----------------------------------------------------------------------------
logic [31:0]         m_debug;
logic [15:0]         m_period;
logic                m_pwr;
logic                m_relay;
logic [NUM_AXES-1:0] m_dis;        // sticky axis disables
logic                m_wdog;
pwr_state_t          m_state;

task automatic reset_model();
    m_debug  = 32'd0;
    m_period = WDOG_PERIOD_RST;
    m_pwr    = 1'b0;
    m_relay  = 1'b0;
    m_dis    = '1;
    m_wdog   = 1'b0;
    m_state  = PWR_OFF;
endtask

// masked status command, axes only follow if power was already on
task automatic apply_status_write(input logic [31:0] d);
    wdata_u w;
    logic   on_cmd;
    logic   off_cmd;
    w.raw   = d;
    on_cmd  = w.cmd.pwr_mask & w.cmd.pwr_value;
    off_cmd = w.cmd.pwr_mask & ~w.cmd.pwr_value;
    for (int i = 0; i < NUM_AXES; i++) begin
        if (w.cmd.amp_mask[i])
            m_dis[i] = ~w.cmd.amp_value[i];
    end
    if (!m_pwr || off_cmd)
        m_dis = '1;
    if (w.cmd.pwr_mask)
        m_pwr = w.cmd.pwr_value;
    if (w.cmd.relay_mask)
        m_relay = w.cmd.relay_value;
    if (on_cmd || (|(w.cmd.amp_mask & w.cmd.amp_value)))
        m_wdog = 1'b0;             // power-up clears the trip
    if (off_cmd)
        m_state = PWR_OFF;
    else if (on_cmd && (m_state == PWR_OFF || m_state == PWR_TRIP))
        m_state = PWR_WAIT;
endtask

task automatic apply_write(input logic [15:0] a, input logic [31:0] d);
    if (a[15:12] == ADDR_MAIN && a[7:4] == 4'd0) begin
        case (a[3:0])
            REG_STATUS:  apply_status_write(d);
            REG_TIMEOUT: m_period = d[15:0];
            REG_DEBUG:   m_debug  = d;
            default: ;
        endcase
    end
endtask

function automatic status_word_t expected_status();
    status_word_t s;
    s                    = '0;
    s.num_chan           = 4'(NUM_AXES);
    s.board_id           = pins.board_id;
    s.wdog_timeout       = m_wdog;
    s.mv_good            = pins.mv_good;
    s.pwr_enable         = m_pwr;
    s.relay_open         = ~pins.relay;
    s.relay_on           = m_relay;
    s.mv_fault           = ~pins.mv_faultn;
    s.fault              = pins.fault;
    s.safety_amp_disable = pins.safety_amp_disable;
    s.amp_enabled        = ~m_dis;
    return s;
endfunction

// amplifiers only run in PWR_ON
function automatic logic [NUM_AXES-1:0] expected_amp_disable();
    return m_dis | {NUM_AXES{m_state != PWR_ON}};
endfunction

// expected read word for one address
function automatic logic [31:0] expected_read(input logic [15:0] a);
    if (a[15:12] != ADDR_MAIN || a[7:4] != 4'd0)
        return 32'd0;               // off page
    case (a[3:0])
        REG_STATUS:  return expected_status();
        REG_TIMEOUT: return {16'd0, m_period};
        REG_VERSION: return FW_VERSION;
        REG_TEMPSNS: return {16'd0, pins.temp_sense};
        REG_DIGIN:   return {pins.v_fault, 3'd0,
                             pins.enc_a, pins.enc_b, pins.enc_i,
                             pins.dout_low,
                             pins.neg_limit, pins.pos_limit, pins.home};
        REG_DEBUG:   return m_debug;
        default:     return 32'd0;
    endcase
endfunction

`endif

//--- testbench/tb_board.sv
/* testbench for board_top, random data from a 32-bit LFSR
   the settle waits run about two million clocks each */

module tb_board import board_pkg::*; ();

    logic                sysclk;
    logic                rst;
    logic [15:0]         reg_raddr;
    logic [15:0]         reg_waddr;
    logic [31:0]         reg_wdata;
    logic                reg_wen;
    board_in_t           pins;
    logic [31:0]         reg_rdata;
    logic                pwr_enable;
    logic                relay_on;
    logic [NUM_AXES-1:0] amp_disable;
    logic [31:0]         lfsr;
    int                  errors;
    int                  checks;

    `include "tb_board_model.svh"

    board_top dut0 (.*);

    always #2 sysclk = ~sysclk;         // period 4

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = 32'd0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32 22 2 1
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %08h expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [31:0] d);
        @(posedge sysclk);
        reg_waddr <= a;
        reg_wdata <= d;
        reg_wen   <= 1'b1;
        @(posedge sysclk);
        reg_wen   <= 1'b0;
        apply_write(a, d);
    endtask

    // write strobe and a new read address in the same cycle
    task automatic write_and_move_read(input logic [15:0] a, input logic [31:0] d,
                                       input logic [15:0] ra);
        @(posedge sysclk);
        reg_raddr <= ra;
        reg_waddr <= a;
        reg_wdata <= d;
        reg_wen   <= 1'b1;
        @(posedge sysclk);
        reg_wen   <= 1'b0;
        apply_write(a, d);
        @(negedge sysclk);
    endtask

    task automatic read_check(input logic [15:0] a, input string name);
        @(posedge sysclk);
        reg_raddr <= a;
        @(posedge sysclk);
        @(negedge sysclk);                  // rdata registered one cycle later
        check(name, reg_rdata, expected_read(a));
    endtask

    // new pin values, mv_good and safety disables kept as given
    task automatic shuffle_pins(input logic mv_good, input logic [NUM_AXES-1:0] safety);
        board_in_t p;
        p                    = board_in_t'({rand_bits(32), 28'(rand_bits(28))});
        p.mv_good            = mv_good;
        p.safety_amp_disable = safety;
        @(posedge sysclk);
        pins <= p;
        @(posedge sysclk);
    endtask

    task automatic wait_amp_disable(input logic [NUM_AXES-1:0] exp, input int limit);
        int n;
        @(negedge sysclk);
        for (n = 0; n < limit && amp_disable !== exp; n++)
            @(negedge sysclk);
        if (amp_disable !== exp)
            abort_on_timeout("amp_disable");
    endtask

    task automatic end_test(input int n);
        $display("test %0d done, %0d errors so far", n, errors);
    endtask

    // ------------------------------------------------------------------------
    // sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [15:0]  a;
        logic [31:0]  d;
        logic [3:0]   x;
        status_word_t st;
        int           n;
        sysclk    = 1'b0;
        rst       = 1'b1;
        reg_raddr = 16'd0;
        reg_waddr = 16'd0;
        reg_wdata = 32'd0;
        reg_wen   = 1'b0;
        pins      = '0;
        lfsr      = 32'hba87_113e;
        errors    = 0;
        checks    = 0;
        reset_model();
        repeat (4) @(posedge sysclk);
        rst <= 1'b0;
        shuffle_pins(1'b0, '0);

        // 1 reset values
        read_check({ADDR_MAIN, 8'h0, REG_STATUS}, "status");
        read_check({ADDR_MAIN, 8'h0, REG_TIMEOUT}, "timeout");
        read_check({ADDR_MAIN, 8'h0, REG_VERSION}, "version");
        read_check({ADDR_MAIN, 8'h0, REG_DEBUG}, "debug");
        check("amp_disable", 32'(amp_disable), 32'(expected_amp_disable()));
        end_test(1);

        // 2 register writes, unmapped and off-page accesses
        for (int i = 0; i < 20; i++) begin
            bus_write({ADDR_MAIN, 8'h0, REG_DEBUG}, rand_bits(32));
            bus_write({ADDR_MAIN, 8'h0, REG_TIMEOUT}, rand_bits(32));
            a = 16'(rand_bits(16));
            if (a[15:12] == ADDR_MAIN)
                a[15:12] = 4'h1;            // other page
            bus_write(a, rand_bits(32));
            read_check({ADDR_MAIN, 8'h0, REG_DEBUG}, "debug");
            read_check({ADDR_MAIN, 8'h0, REG_TIMEOUT}, "timeout");
            a = {ADDR_MAIN, 8'h0, 4'(rand_bits(4))};
            read_check(a, "rdata");
            read_check(16'(rand_bits(16)), "rdata");
        end
        read_check({ADDR_MAIN, 8'h0, REG_DIGIN}, "digin");
        read_check({ADDR_MAIN, 8'h0, REG_TEMPSNS}, "tempsns");
        read_check({ADDR_MAIN, 8'h0, REG_VERSION}, "version");
        // version word stays on rdata through the write cycle
        write_and_move_read({ADDR_MAIN, 8'h0, REG_DEBUG}, rand_bits(32),
                            {ADDR_MAIN, 8'h0, REG_DEBUG});
        check("held rdata", reg_rdata, FW_VERSION);
        read_check({ADDR_MAIN, 8'h0, REG_DEBUG}, "debug");
        bus_write({ADDR_MAIN, 8'h0, REG_TIMEOUT}, 32'd0);   // watchdog off
        read_check({ADDR_MAIN, 8'h0, REG_TIMEOUT}, "timeout");
        end_test(2);

        // 3 random masked status writes
        for (int i = 0; i < 40; i++) begin
            d = {12'd0, 4'(rand_bits(4)), 4'd0, 4'(rand_bits(4)), 4'd0, 4'(rand_bits(4))};
            bus_write({ADDR_MAIN, 8'h0, REG_STATUS}, d);
            @(negedge sysclk);
            check("pwr_enable", 32'(pwr_enable), 32'(m_pwr));
            check("relay_on", 32'(relay_on), 32'(m_relay));
            check("amp_disable", 32'(amp_disable), 32'(expected_amp_disable()));
            read_check({ADDR_MAIN, 8'h0, REG_STATUS}, "status");
        end
        bus_write({ADDR_MAIN, 8'h0, REG_STATUS}, 32'h0008_0000);   // power off
        read_check({ADDR_MAIN, 8'h0, REG_STATUS}, "status");
        end_test(3);

        // 4 settle time gating
        bus_write({ADDR_MAIN, 8'h0, REG_STATUS}, 32'h000f_0000);   // power and relay on
        bus_write({ADDR_MAIN, 8'h0, REG_STATUS}, 32'h0000_0f05);   // axes 1 and 3
        shuffle_pins(1'b1, '0);
        @(negedge sysclk);
        check("amp_disable", 32'(amp_disable), 32'(expected_amp_disable()));
        m_state = PWR_ON;                   // once the voltage has settled
        wait_amp_disable(expected_amp_disable(), 2_500_000);
        read_check({ADDR_MAIN, 8'h0, REG_STATUS}, "status");
        @(posedge sysclk);
        pins.mv_good <= 1'b0;
        m_state = PWR_WAIT;
        @(posedge sysclk);
        @(posedge sysclk);
        @(negedge sysclk);
        check("amp_disable", 32'(amp_disable), 32'(expected_amp_disable()));
        @(posedge sysclk);
        pins.mv_good <= 1'b1;
        m_state = PWR_ON;
        wait_amp_disable(expected_amp_disable(), 2_500_000);
        end_test(4);

        // 5 watchdog trip and recovery
        bus_write({ADDR_MAIN, 8'h0, REG_TIMEOUT}, 32'd2);
        st = '0;
        for (n = 0; n < 2000 && !st.wdog_timeout; n++) begin
            @(posedge sysclk);
            reg_raddr <= {ADDR_MAIN, 8'h0, REG_STATUS};
            @(negedge sysclk);
            st = reg_rdata;
        end
        if (!st.wdog_timeout)
            abort_on_timeout("watchdog trip");
        m_wdog  = 1'b1;
        m_dis   = '1;
        m_state = PWR_TRIP;
        read_check({ADDR_MAIN, 8'h0, REG_STATUS}, "status");
        check("amp_disable", 32'(amp_disable), 32'(expected_amp_disable()));
        bus_write({ADDR_MAIN, 8'h0, REG_TIMEOUT}, 32'd0);
        bus_write({ADDR_MAIN, 8'h0, REG_STATUS}, 32'h000c_0f0f);   // power-up, all axes
        m_state = PWR_ON;                   // voltage is still settled
        wait_amp_disable(expected_amp_disable(), 20);
        read_check({ADDR_MAIN, 8'h0, REG_STATUS}, "status");
        end_test(5);

        // 6 sticky safety disable
        x = 4'(rand_bits(4)) | 4'h1;
        @(posedge sysclk);
        pins.safety_amp_disable <= x;
        @(posedge sysclk);
        pins.safety_amp_disable <= '0;
        m_dis = m_dis | x;
        repeat (3) @(posedge sysclk);
        @(negedge sysclk);
        check("amp_disable", 32'(amp_disable), 32'(expected_amp_disable()));
        read_check({ADDR_MAIN, 8'h0, REG_STATUS}, "status");
        bus_write({ADDR_MAIN, 8'h0, REG_STATUS}, 32'h0000_0f0f);
        @(negedge sysclk);
        check("amp_disable", 32'(amp_disable), 32'(expected_amp_disable()));
        end_test(6);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- src.f
+incdir+testbench
logic/board_pkg.sv
logic/board_reg_file.sv
logic/board_timers.sv
logic/power_ctrl_fsm.sv
logic/board_top.sv
testbench/tb_board.sv

//--- run_sim.sh
#!/bin/sh
# builds with Verilator and runs the testbench, status follows the log
verilator --binary -f src.f --top-module tb_board -o tb_board_sim \
    && ./obj_dir/tb_board_sim > sim.log \
    ; cat sim.log \
    && grep -q "Simulation finished: PASS" sim.log \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
